//--- run_sim.sh
#!/usr/bin/env bash
# builds the loopback testbench with Verilator and runs it
set -u
cd "$(dirname "$0")" || exit 1

BUILD_LOG=build.log
SIM_LOG=sim.log

verilator --binary --timing --assert -Wno-fatal \
  --top-module tb_wb_spi_master -f wb_spi_master.f -o sim_tb > "$BUILD_LOG" 2>&1
if [ $? -ne 0 ]; then
  cat "$BUILD_LOG"
  echo "build failed"
  exit 1
fi

./obj_dir/sim_tb > "$SIM_LOG" 2>&1
status=$?
cat "$SIM_LOG"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -qx "ALL TESTS PASSED" "$SIM_LOG"; then
  exit 0
fi
exit 1

//--- src/spi_master.sv
`timescale 1ns/1ps
`default_nettype none

module spi_master #(
  parameter int NBITS       = 24,
  parameter int NCLKDIVBITS = 5,
  parameter int NCSBITS     = 3
) (
  input  wire logic              wb_clk_i,
  input  wire logic              wb_rst_i,
  input  wire logic              cmd_valid_i,
  input  wire spi_pkg::spi_cmd_t cmd_i,
  input  wire logic              rsp_ack_i,
  input  wire logic              miso_i,
  output logic                   rsp_valid_o,
  output spi_pkg::spi_rsp_t      rsp_o,
  output logic                   busy_o,
  output logic [NCSBITS-1:0]     cs_n_o,
  output logic                   sclk_o,
  output logic                   mosi_o
);
  import spi_pkg::*;

  logic [NCSBITS-1:0] cs_q;
  wb_data_t           rx_data;
  logic               active;
  logic               done;
  logic               rise_stb;
  logic               fall_stb;

  always_ff @(posedge wb_clk_i) begin
    if (cmd_valid_i) begin
      cs_q <= cmd_i.cs_pattern[NCSBITS-1:0];
    end
  end

  assign busy_o      = active || done;  // shifting or holding a result
  assign cs_n_o      = busy_o ? cs_q : '1;
  assign rsp_valid_o = done;
  assign rsp_o       = '{rx_data: rx_data};

  spi_sclk_gen #(
    .NCLKDIVBITS (NCLKDIVBITS)
  ) u_sclk (
    .wb_clk_i   (wb_clk_i),
    .wb_rst_i   (wb_rst_i),
    .active_i   (active),
    .sclk_o     (sclk_o),
    .rise_stb_o (rise_stb),
    .fall_stb_o (fall_stb)
  );

  spi_shifter #(
    .NBITS (NBITS)
  ) u_shift (
    .wb_clk_i   (wb_clk_i),
    .wb_rst_i   (wb_rst_i),
    .start_i    (cmd_valid_i),
    .tx_data_i  (cmd_i.tx_data),
    .rise_stb_i (rise_stb),
    .fall_stb_i (fall_stb),
    .miso_i     (miso_i),
    .rsp_ack_i  (rsp_ack_i),
    .active_o   (active),
    .mosi_o     (mosi_o),
    .rx_data_o  (rx_data),
    .done_o     (done)
  );

endmodule

`default_nettype wire

//--- src/spi_pkg.sv
`default_nettype none

package spi_pkg;

  typedef logic [31:0] wb_data_t;
  typedef logic [3:0]  wb_sel_t;
  typedef logic [7:0]  cs_byte_t;
  typedef logic [2:0]  reg_idx_t; // word address bits 4:2

  // register word indices
  localparam reg_idx_t REG_CS    = 3'd0;
  localparam reg_idx_t REG_TX    = 3'd1;
  localparam reg_idx_t REG_RX    = 3'd2;
  localparam reg_idx_t REG_COUNT = 3'd3;

  typedef struct packed {
    wb_data_t tx_data;    // low NBITS bits are shifted out
    cs_byte_t cs_pattern;
  } spi_cmd_t;

  typedef struct packed {
    wb_data_t rx_data;    // zero above NBITS
  } spi_rsp_t;

  typedef enum logic [1:0] {
    IDLE,
    SHIFT,
    HOLD
  } shift_state_e;

endpackage

`default_nettype wire

//--- src/spi_sclk_gen.sv
`timescale 1ns/1ps
`default_nettype none

module spi_sclk_gen #(
  parameter int NCLKDIVBITS = 5
) (
  input  wire logic wb_clk_i,
  input  wire logic wb_rst_i,
  input  wire logic active_i,
  output logic      sclk_o,
  output logic      rise_stb_o,
  output logic      fall_stb_o
);

  logic [NCLKDIVBITS-1:0] div_q;

  // half period is 2**NCLKDIVBITS clocks
  always_ff @(posedge wb_clk_i) begin
    rise_stb_o <= 1'b0;
    fall_stb_o <= 1'b0;
    if (wb_rst_i || !active_i) begin
      // restart from zero so each transfer sees the same first half period
      div_q  <= '0;
      sclk_o <= 1'b0;
    end else begin
      div_q <= div_q + 1'b1;
      if (&div_q) begin
        sclk_o     <= ~sclk_o;
        rise_stb_o <= ~sclk_o; // strobe lines up with the new level
        fall_stb_o <= sclk_o;
      end
    end
  end

endmodule

`default_nettype wire

//--- src/spi_shifter.sv
`timescale 1ns/1ps
`default_nettype none

module spi_shifter #(
  parameter int NBITS = 24
) (
  input  wire logic              wb_clk_i,
  input  wire logic              wb_rst_i,
  input  wire logic              start_i,
  input  wire spi_pkg::wb_data_t tx_data_i,
  input  wire logic              rise_stb_i,
  input  wire logic              fall_stb_i,
  input  wire logic              miso_i,
  input  wire logic              rsp_ack_i,
  output logic                   active_o,
  output logic                   mosi_o,
  output spi_pkg::wb_data_t      rx_data_o,
  output logic                   done_o
);
  import spi_pkg::*;

  localparam int CNTW = $clog2(NBITS + 1);

  shift_state_e     state_q;
  logic [CNTW-1:0]  bit_cnt_q;  // bits sampled so far
  logic [NBITS-1:0] tx_sr_q;
  logic [NBITS-1:0] rx_sr_q;
  logic             last_bit;

  assign last_bit = (bit_cnt_q == CNTW'(NBITS));

  always_ff @(posedge wb_clk_i) begin
    if (wb_rst_i) begin
      state_q   <= IDLE;
      bit_cnt_q <= '0;
    end else begin
      case (state_q)
        IDLE: begin
          if (start_i) begin
            state_q   <= SHIFT;
            bit_cnt_q <= '0;
          end
        end
        SHIFT: begin
          if (rise_stb_i) bit_cnt_q <= bit_cnt_q + 1'b1;
          if (fall_stb_i && last_bit) state_q <= HOLD; // last low half done
        end
        HOLD: begin
          if (rsp_ack_i) state_q <= IDLE;
        end
        default: state_q <= IDLE;
      endcase
    end
  end

  // data path, MSB first
  always_ff @(posedge wb_clk_i) begin
    if (state_q == IDLE && start_i) begin
      tx_sr_q <= tx_data_i[NBITS-1:0];
    end else if (state_q == SHIFT && fall_stb_i && !last_bit) begin
      tx_sr_q <= NBITS'({tx_sr_q, 1'b0});
    end
    if (state_q == SHIFT && rise_stb_i) begin
      rx_sr_q <= NBITS'({rx_sr_q, miso_i});
    end
  end

  assign active_o  = (state_q == SHIFT);
  assign done_o    = (state_q == HOLD);
  assign mosi_o    = active_o && tx_sr_q[NBITS-1];
  assign rx_data_o = wb_data_t'(rx_sr_q);

  a_bit_cnt_range: assert property (
    @(posedge wb_clk_i) disable iff (wb_rst_i)
    bit_cnt_q <= CNTW'(NBITS)
  );

endmodule

`default_nettype wire

//--- src/wb_spi_master.sv
`timescale 1ns/1ps
`default_nettype none

module wb_spi_master #(
  parameter int NBITS       = 24,
  parameter int NCLKDIVBITS = 5,
  parameter int NCSBITS     = 3
) (
  input  wire logic              wb_clk_i,
  input  wire logic              wb_rst_i,
  input  wire spi_pkg::wb_data_t wb_adr_i,
  input  wire spi_pkg::wb_data_t wb_dat_i,
  input  wire spi_pkg::wb_sel_t  wb_sel_i,
  input  wire logic              wb_we_i,
  input  wire logic              wb_cyc_i,
  input  wire logic              wb_stb_i,
  output spi_pkg::wb_data_t      wb_dat_o,
  output logic                   wb_ack_o,
  output logic                   wb_err_o,
  output logic [NCSBITS-1:0]     cs_n_o,
  output logic                   sclk_o,
  output logic                   mosi_o,
  input  wire logic              miso_i
);
  import spi_pkg::*;

  spi_cmd_t cmd;
  spi_rsp_t rsp;
  logic     cmd_valid;
  logic     rsp_valid;
  logic     rsp_ack;
  logic     busy;

  wb_spi_regs u_regs (
    .wb_clk_i    (wb_clk_i),
    .wb_rst_i    (wb_rst_i),
    .wb_adr_i    (wb_adr_i),
    .wb_dat_i    (wb_dat_i),
    .wb_sel_i    (wb_sel_i),
    .wb_we_i     (wb_we_i),
    .wb_cyc_i    (wb_cyc_i),
    .wb_stb_i    (wb_stb_i),
    .wb_dat_o    (wb_dat_o),
    .wb_ack_o    (wb_ack_o),
    .wb_err_o    (wb_err_o),
    .cmd_valid_o (cmd_valid),
    .cmd_o       (cmd),
    .rsp_ack_o   (rsp_ack),
    .rsp_valid_i (rsp_valid),
    .rsp_i       (rsp),
    .busy_i      (busy)
  );

  spi_master #(
    .NBITS       (NBITS),
    .NCLKDIVBITS (NCLKDIVBITS),
    .NCSBITS     (NCSBITS)
  ) u_spi (
    .wb_clk_i    (wb_clk_i),
    .wb_rst_i    (wb_rst_i),
    .cmd_valid_i (cmd_valid),
    .cmd_i       (cmd),
    .rsp_ack_i   (rsp_ack),
    .miso_i      (miso_i),
    .rsp_valid_o (rsp_valid),
    .rsp_o       (rsp),
    .busy_o      (busy),
    .cs_n_o      (cs_n_o),
    .sclk_o      (sclk_o),
    .mosi_o      (mosi_o)
  );

endmodule

`default_nettype wire

//--- src/wb_spi_regs.sv
`timescale 1ns/1ps
`default_nettype none

module wb_spi_regs (
  input  wire logic              wb_clk_i,
  input  wire logic              wb_rst_i,
  input  wire spi_pkg::wb_data_t wb_adr_i,
  input  wire spi_pkg::wb_data_t wb_dat_i,
  input  wire spi_pkg::wb_sel_t  wb_sel_i,
  input  wire logic              wb_we_i,
  input  wire logic              wb_cyc_i,
  input  wire logic              wb_stb_i,
  output spi_pkg::wb_data_t      wb_dat_o,
  output logic                   wb_ack_o,
  output logic                   wb_err_o,
  output logic                   cmd_valid_o,
  output spi_pkg::spi_cmd_t      cmd_o,
  output logic                   rsp_ack_o,
  input  wire logic              rsp_valid_i,
  input  wire spi_pkg::spi_rsp_t rsp_i,
  input  wire logic              busy_i
);
  import spi_pkg::*;

  wb_data_t tx_reg;
  wb_data_t rx_reg;
  wb_data_t count_reg;
  wb_data_t rdata_q;
  cs_byte_t cs_reg;
  reg_idx_t word_adr;
  logic     pending_q;  // CS write waiting for the transfer to finish
  logic     req;
  logic     bad_adr;

  assign word_adr = wb_adr_i[4:2];
  // anything past REG_COUNT, including set upper bits, is an error
  assign bad_adr  = (|wb_adr_i[31:5]) || (word_adr > REG_COUNT);

  // new access, not the one already answered in this cycle
  assign req = wb_cyc_i && wb_stb_i && !wb_ack_o && !wb_err_o && !pending_q;

  always_ff @(posedge wb_clk_i) begin
    wb_ack_o    <= 1'b0;
    wb_err_o    <= 1'b0;
    cmd_valid_o <= 1'b0;
    rsp_ack_o   <= 1'b0;
    rdata_q     <= '0;
    if (wb_rst_i) begin
      pending_q <= 1'b0;
      tx_reg    <= '0;
      cs_reg    <= '0;
      rx_reg    <= '0;
      count_reg <= '0;
    end else if (pending_q) begin
      if (rsp_valid_i) begin
        rx_reg    <= rsp_i.rx_data;
        count_reg <= count_reg + 32'd1;
        pending_q <= 1'b0;
        rsp_ack_o <= 1'b1;
        wb_ack_o  <= 1'b1;  // closes the CS write
      end
    end else if (req) begin
      if (bad_adr) begin
        wb_err_o <= 1'b1;
      end else if (wb_we_i) begin
        case (word_adr)
          REG_CS: begin
            if (!wb_sel_i[0]) begin
              wb_ack_o <= 1'b1;   // no lane 0, nothing to start
            end else if (!busy_i) begin
              cs_reg      <= wb_dat_i[7:0];
              cmd_valid_o <= 1'b1;
              pending_q   <= 1'b1;
            end
          end
          REG_TX: begin
            wb_ack_o <= 1'b1;
            for (int i = 0; i < 4; i++) begin
              if (wb_sel_i[i]) begin
                tx_reg[8*i +: 8] <= wb_dat_i[8*i +: 8];
              end
            end
          end
          default: begin
            wb_ack_o <= 1'b1;  // rx and count are read-only
          end
        endcase
      end else begin
        wb_ack_o <= 1'b1;
        case (word_adr)
          REG_CS:  rdata_q <= wb_data_t'(cs_reg);
          REG_TX:  rdata_q <= tx_reg;
          REG_RX:  rdata_q <= rx_reg;
          default: rdata_q <= count_reg;
        endcase
      end
    end
  end

  // zero outside a read ack
  assign wb_dat_o = rdata_q;

  assign cmd_o = '{tx_data: tx_reg, cs_pattern: cs_reg};

  a_ack_err_excl: assert property (
    @(posedge wb_clk_i) disable iff (wb_rst_i)
    !(wb_ack_o && wb_err_o)
  );

  // the core must be idle when a new transfer is issued
  a_cmd_not_busy: assert property (
    @(posedge wb_clk_i) disable iff (wb_rst_i)
    cmd_valid_o |-> !busy_i
  );

endmodule

`default_nettype wire

//--- verification/tb_wb_spi_master.sv
`timescale 1ns/1ps
`default_nettype none

module tb_wb_spi_master;
  import spi_pkg::*;

  localparam int NBITS       = 24;
  localparam int NCLKDIVBITS = 2;
  localparam int NCSBITS     = 3;
  localparam int CLK_PERIOD  = 10;
  localparam int N_XFER      = 8;
  // one transfer, worst case, in clock cycles
  localparam int XFER_CYCLES = NBITS * (2 ** (NCLKDIVBITS + 1)) + 10;
  localparam int WATCHDOG_NS = (N_XFER * XFER_CYCLES + 300) * CLK_PERIOD;

  logic               wb_clk_i;
  logic               wb_rst_i;
  wb_data_t           wb_adr_i;
  wb_data_t           wb_dat_i;
  wb_sel_t            wb_sel_i;
  logic               wb_we_i;
  logic               wb_cyc_i;
  logic               wb_stb_i;
  wb_data_t           wb_dat_o;
  logic               wb_ack_o;
  logic               wb_err_o;
  logic [NCSBITS-1:0] cs_n_o;
  logic               sclk_o;
  logic               mosi_o;
  logic               miso_i;

  int                 errors;
  int                 tests_run;
  int                 tests_failed;
  int                 rise_cnt;
  logic               sclk_q;
  logic [NCSBITS-1:0] exp_cs;  // pattern of the transfer in flight

  assign miso_i = mosi_o;  // loopback

  wb_spi_master #(
    .NBITS       (NBITS),
    .NCLKDIVBITS (NCLKDIVBITS),
    .NCSBITS     (NCSBITS)
  ) i_wb_spi_master (
    .wb_clk_i (wb_clk_i),
    .wb_rst_i (wb_rst_i),
    .wb_adr_i (wb_adr_i),
    .wb_dat_i (wb_dat_i),
    .wb_sel_i (wb_sel_i),
    .wb_we_i  (wb_we_i),
    .wb_cyc_i (wb_cyc_i),
    .wb_stb_i (wb_stb_i),
    .wb_dat_o (wb_dat_o),
    .wb_ack_o (wb_ack_o),
    .wb_err_o (wb_err_o),
    .cs_n_o   (cs_n_o),
    .sclk_o   (sclk_o),
    .mosi_o   (mosi_o),
    .miso_i   (miso_i)
  );

  initial begin
    wb_clk_i = 1'b0;
    forever #(CLK_PERIOD / 2) wb_clk_i = ~wb_clk_i;
  end

  // counts rising sclk edges as seen at the system clock
  always @(posedge wb_clk_i) begin
    if (wb_rst_i) begin
      sclk_q   <= 1'b0;
      rise_cnt <= 0;
    end else begin
      sclk_q <= sclk_o;
      if (sclk_o && !sclk_q) rise_cnt <= rise_cnt + 1;
    end
  end

  a_ack_err_excl: assert property (
    @(posedge wb_clk_i) disable iff (wb_rst_i)
    !(wb_ack_o && wb_err_o)
  ) else begin
    $display("%0t ns: ack and err were high in the same cycle", $time);
    errors++;
  end

  a_sclk_idle_low: assert property (
    @(posedge wb_clk_i) disable iff (wb_rst_i)
    (&cs_n_o) |-> !sclk_o
  ) else begin
    $display("%0t ns: sclk high with no chip select active", $time);
    errors++;
  end

  a_cs_during_sclk: assert property (
    @(posedge wb_clk_i) disable iff (wb_rst_i)
    sclk_o |-> (cs_n_o == exp_cs)
  ) else begin
    $display("FAIL %0t ns cs_n_o expected %b got %b", $time, exp_cs, cs_n_o);
    errors++;
  end

  // read data only on the ack cycle
  a_dat_zero_idle: assert property (
    @(posedge wb_clk_i) disable iff (wb_rst_i)
    !wb_ack_o |-> (wb_dat_o == '0)
  ) else begin
    $display("FAIL %0t ns wb_dat_o expected 0 got %h", $time, wb_dat_o);
    errors++;
  end

  initial begin
    #(WATCHDOG_NS);
    $display("timeout: run still going after %0d ns", WATCHDOG_NS);
    $display("SOME TESTS FAILED");
    $finish;
  end

  function automatic wb_data_t merge_lanes(input wb_data_t old_w, input wb_data_t new_w,
                                           input wb_sel_t sel);
    wb_data_t mask;
    mask = {{8{sel[3]}}, {8{sel[2]}}, {8{sel[1]}}, {8{sel[0]}}};
    return (old_w & ~mask) | (new_w & mask);
  endfunction

  task automatic check_value(input string name, input wb_data_t exp, input wb_data_t act);
    assert (act === exp) else begin
      $display("FAIL %0t ns %s expected %h got %h", $time, name, exp, act);
      errors++;
    end
  endtask

  task automatic finish_test(input string name, input int errs_before);
    tests_run++;
    if (errors == errs_before) begin
      $display("test %s: pass", name);
    end else begin
      tests_failed++;
      $display("test %s: fail with %0d errors", name, errors - errs_before);
    end
  endtask

  // one classic cycle, held until ack or err
  task automatic wb_access(input wb_data_t adr, input logic we, input wb_data_t dat,
                           input wb_sel_t sel, output wb_data_t rdata,
                           output logic ack, output logic err);
    @(posedge wb_clk_i);
    wb_adr_i <= adr;
    wb_dat_i <= dat;
    wb_sel_i <= sel;
    wb_we_i  <= we;
    wb_cyc_i <= 1'b1;
    wb_stb_i <= 1'b1;
    @(posedge wb_clk_i);
    while (!(wb_ack_o || wb_err_o)) @(posedge wb_clk_i);
    rdata = wb_dat_o;
    ack   = wb_ack_o;
    err   = wb_err_o;
    wb_cyc_i <= 1'b0;
    wb_stb_i <= 1'b0;
    wb_we_i  <= 1'b0;
  endtask

  task automatic reg_write(input reg_idx_t idx, input wb_data_t dat, input wb_sel_t sel);
    wb_data_t rd;
    logic     ack;
    logic     err;
    wb_access(wb_data_t'({idx, 2'b00}), 1'b1, dat, sel, rd, ack, err);
    check_value("wb_ack_o", 32'd1, wb_data_t'(ack));
    check_value("wb_err_o", 32'd0, wb_data_t'(err));
  endtask

  task automatic reg_read(input reg_idx_t idx, output wb_data_t rdata);
    logic ack;
    logic err;
    wb_access(wb_data_t'({idx, 2'b00}), 1'b0, '0, 4'hf, rdata, ack, err);
    check_value("wb_ack_o", 32'd1, wb_data_t'(ack));
    check_value("wb_err_o", 32'd0, wb_data_t'(err));
  endtask

  initial begin
    wb_data_t rd;
    wb_data_t word;
    wb_data_t old_tx;
    wb_data_t exp_tx;
    wb_data_t rx_mask;
    cs_byte_t pat;
    logic     ack;
    logic     err;
    int       e0;
    int       rise0;
    int       seed;

    seed     = $urandom(30);
    errors   = 0;
    tests_run    = 0;
    tests_failed = 0;
    exp_cs   = '1;
    rx_mask  = (32'h1 << NBITS) - 32'h1;
    wb_rst_i = 1'b1;
    wb_adr_i = '0;
    wb_dat_i = '0;
    wb_sel_i = '0;
    wb_we_i  = 1'b0;
    wb_cyc_i = 1'b0;
    wb_stb_i = 1'b0;
    repeat (3) @(posedge wb_clk_i);
    wb_rst_i <= 1'b0;

    e0 = errors;
    @(posedge wb_clk_i);
    check_value("cs_n_o", 32'h7, wb_data_t'(cs_n_o));
    check_value("sclk_o", 32'h0, wb_data_t'(sclk_o));
    for (int i = 0; i < 4; i++) begin
      reg_read(reg_idx_t'(i), rd);
      check_value($sformatf("reg %0d", i), 32'h0, rd);
    end
    finish_test("reset_state", e0);

    e0 = errors;
    old_tx = $urandom;
    reg_write(REG_TX, old_tx, 4'hf);
    reg_read(REG_TX, rd);
    check_value("REG_TX", old_tx, rd);
    word = $urandom;
    exp_tx = merge_lanes(old_tx, word, 4'b0101);
    reg_write(REG_TX, word, 4'b0101);
    reg_read(REG_TX, rd);
    check_value("REG_TX", exp_tx, rd);
    word = $urandom;
    exp_tx = merge_lanes(exp_tx, word, 4'b1010);
    reg_write(REG_TX, word, 4'b1010);
    reg_read(REG_TX, rd);
    check_value("REG_TX", exp_tx, rd);
    finish_test("byte_lanes", e0);

    for (int k = 1; k <= N_XFER; k++) begin
      e0   = errors;
      word = $urandom;
      pat  = cs_byte_t'($urandom);
      if (&pat[NCSBITS-1:0]) pat[0] = 1'b0;  // keep at least one select low
      reg_write(REG_TX, word, 4'hf);
      exp_cs = pat[NCSBITS-1:0];
      rise0  = rise_cnt;
      reg_write(REG_CS, wb_data_t'(pat), 4'hf);
      check_value("sclk rising edges", NBITS, wb_data_t'(rise_cnt - rise0));
      reg_read(REG_RX, rd);
      check_value("REG_RX", word & rx_mask, rd);
      check_value("cs_n_o", 32'h7, wb_data_t'(cs_n_o));
      reg_read(REG_CS, rd);
      check_value("REG_CS", wb_data_t'(pat), rd);
      reg_read(REG_COUNT, rd);
      check_value("REG_COUNT", k, rd);
      finish_test($sformatf("loopback_%0d", k), e0);
    end

    e0 = errors;
    reg_read(REG_COUNT, rd);
    check_value("REG_COUNT", N_XFER, rd);
    finish_test("transfer_count", e0);

    e0 = errors;
    wb_access(32'h14, 1'b0, '0, 4'hf, rd, ack, err);
    check_value("wb_ack_o", 32'd0, wb_data_t'(ack));
    check_value("wb_err_o", 32'd1, wb_data_t'(err));
    wb_access(32'h14, 1'b1, $urandom, 4'hf, rd, ack, err);
    check_value("wb_ack_o", 32'd0, wb_data_t'(ack));
    check_value("wb_err_o", 32'd1, wb_data_t'(err));
    wb_access(32'h1c, 1'b0, '0, 4'hf, rd, ack, err);
    check_value("wb_err_o", 32'd1, wb_data_t'(err));
    reg_read(REG_COUNT, rd);
    check_value("REG_COUNT", N_XFER, rd);
    finish_test("bus_errors", e0);

    $display("%0d tests run, %0d failed, %0d check errors", tests_run, tests_failed, errors);
    if (errors == 0 && tests_failed == 0) begin
      $display("ALL TESTS PASSED");
    end else begin
      $display("SOME TESTS FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- wb_spi_master.f
src/spi_pkg.sv
src/spi_sclk_gen.sv
src/spi_shifter.sv
src/spi_master.sv
src/wb_spi_regs.sv
src/wb_spi_master.sv
verification/tb_wb_spi_master.sv
